// File: src/scan_params.svh
`ifndef SCAN_PARAMS_SVH
`define SCAN_PARAMS_SVH

// horizontal raster, in pixel clocks
`define SCAN_H_VISIBLE    640
`define SCAN_H_TOTAL      800
`define SCAN_H_SYNC_START 656
`define SCAN_H_SYNC_LEN   96

// vertical raster, in lines
`define SCAN_V_VISIBLE    480
`define SCAN_V_TOTAL      525
`define SCAN_V_SYNC_START 490
`define SCAN_V_SYNC_LEN   2

// stored picture width, each pixel shown 2x2 on screen
`define SCAN_LOGICAL_W    320

// one burst fills one buffer bank
`define SCAN_BURST_LEN    16  // 16-bit words per burst
`define SCAN_BLOCK_PIX    32  // pixels per block, two per word

`endif

// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef logic [31:0] bus_addr_t;  // word address
    typedef logic [15:0] bus_data_t;  // two 8-bit pixels, even pixel in the high byte

    // control code: upper nibble is the burst length, bit 1 set for a write
    typedef logic [7:0] bus_ctrl_t;

    parameter bus_ctrl_t BUS_CTRL_RD_BURST16 = 8'h10;

    // fetch engine sequence, one pass per block
    typedef enum logic [2:0] {
        IDLE,
        PRESENT_ADDR,
        WAIT,
        READ_DATA,
        FINISH
    } fetch_state_t;

endpackage

`default_nettype wire

// File: src/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef logic [10:0] raster_t;   // hcount or vcount
    typedef logic [7:0]  pixel_t;    // one stored pixel
    typedef logic [3:0]  buf_addr_t; // word index inside one bank

endpackage

`default_nettype wire

// File: src/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none
`include "scan_params.svh"

module vga_timing
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    output raster_t hcount,
    output raster_t vcount,
    output logic    hsync,
    output logic    vsync,
    output logic    de
);

    localparam raster_t H_VIS      = raster_t'(`SCAN_H_VISIBLE);
    localparam raster_t H_LAST     = raster_t'(`SCAN_H_TOTAL - 1);
    localparam raster_t H_SYNC_BEG = raster_t'(`SCAN_H_SYNC_START);
    localparam raster_t H_SYNC_END = raster_t'(`SCAN_H_SYNC_START + `SCAN_H_SYNC_LEN);
    localparam raster_t V_VIS      = raster_t'(`SCAN_V_VISIBLE);
    localparam raster_t V_LAST     = raster_t'(`SCAN_V_TOTAL - 1);
    localparam raster_t V_SYNC_BEG = raster_t'(`SCAN_V_SYNC_START);
    localparam raster_t V_SYNC_END = raster_t'(`SCAN_V_SYNC_START + `SCAN_V_SYNC_LEN);

    // Reset lands in the horizontal blanking of the last line, so the
    // fetch engine has the whole blanking interval to load block 0 of
    // line 0 before it is shown.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= H_VIS;
            vcount <= V_LAST;
        end else if (hcount == H_LAST) begin
            hcount <= '0;
            if (vcount == V_LAST) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // both syncs active low
    assign hsync = !((hcount >= H_SYNC_BEG) && (hcount < H_SYNC_END));
    assign vsync = !((vcount >= V_SYNC_BEG) && (vcount < V_SYNC_END));
    assign de    = (hcount < H_VIS) && (vcount < V_VIS);

endmodule

`default_nettype wire

// File: src/fb_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "scan_params.svh"

module fb_fetch
    import bus_pkg::*, video_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  bus_addr_t base_addr,
    input  raster_t   hcount,
    input  raster_t   vcount,
    output logic      bus_req,
    input  logic      bus_ack,
    input  logic      bus_wait,
    output bus_addr_t bus_addr,
    output bus_ctrl_t bus_ctrl,
    output logic      buf_wr_en,
    output logic      buf_wr_bank,
    output buf_addr_t buf_wr_addr,
    output logic      idle
);

    localparam raster_t   H_VIS     = raster_t'(`SCAN_H_VISIBLE);
    localparam raster_t   V_VIS     = raster_t'(`SCAN_V_VISIBLE);
    localparam raster_t   V_LAST    = raster_t'(`SCAN_V_TOTAL - 1);
    localparam int        BLOCKS    = `SCAN_LOGICAL_W / `SCAN_BLOCK_PIX;  // 10 per line
    localparam buf_addr_t LAST_BEAT = buf_addr_t'(`SCAN_BURST_LEN - 1);

    fetch_state_t state;

    logic [9:0] cur_lcol;     // logical column under the beam
    logic [3:0] cur_block;
    raster_t    next_line;
    raster_t    tgt_row;      // logical row of the wanted block
    logic [3:0] tgt_block;
    logic       tgt_valid;
    bus_addr_t  tgt_addr;
    logic       fetch_due;
    logic       disp_active;

    bus_addr_t  last_addr;    // block most recently requested
    logic       last_valid;
    logic       wr_bank_q;
    buf_addr_t  beat;

    assign cur_lcol    = hcount[10:1];
    assign cur_block   = 4'(cur_lcol / `SCAN_BLOCK_PIX);
    assign disp_active = (hcount < H_VIS) && (vcount < V_VIS);

    // lookahead: next block on this line, or block 0 of the next line in blanking
    always_comb begin
        if (vcount == V_LAST) begin
            next_line = '0;
        end else begin
            next_line = vcount + 1'b1;
        end
        if (hcount < H_VIS) begin
            tgt_row   = vcount >> 1;
            tgt_block = cur_block + 4'd1;
            tgt_valid = (vcount < V_VIS) && (cur_block < 4'(BLOCKS - 1));
        end else begin
            tgt_row   = next_line >> 1;
            tgt_block = '0;
            tgt_valid = next_line < V_VIS;
        end
    end

    assign tgt_addr = base_addr + ((bus_addr_t'(tgt_row) * `SCAN_LOGICAL_W
                                  + bus_addr_t'(tgt_block) * `SCAN_BLOCK_PIX) >> 1);

    assign fetch_due = tgt_valid && (!last_valid || (tgt_addr != last_addr));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            bus_req    <= 1'b0;
            last_valid <= 1'b0;
            beat       <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!bus_req && fetch_due) begin
                        bus_req    <= 1'b1;  // address is latched in the same edge
                        last_valid <= 1'b1;
                    end else if (bus_req && bus_ack) begin
                        state <= PRESENT_ADDR;
                    end
                end
                PRESENT_ADDR: begin
                    state <= WAIT;
                end
                WAIT: begin
                    if (!bus_wait) begin
                        state <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    beat <= beat + 1'b1;  // wraps back to 0 after the last beat
                    if (beat == LAST_BEAT) begin
                        state   <= FINISH;
                        bus_req <= 1'b0;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request address and target bank, held for the whole burst
    always_ff @(posedge clk) begin
        if (state == IDLE && !bus_req && fetch_due) begin
            last_addr <= tgt_addr;
            wr_bank_q <= tgt_block[0];
        end
    end

    assign bus_addr    = last_addr;
    assign bus_ctrl    = BUS_CTRL_RD_BURST16;
    assign buf_wr_en   = (state == READ_DATA);
    assign buf_wr_bank = wr_bank_q;
    assign buf_wr_addr = beat;
    assign idle        = (state == IDLE) && !bus_req;

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bus_req && $past(bus_req)) |-> $stable(bus_addr)
    ) else $error("bus_addr changed during a request");

    // the burst must never land in the bank on screen
    a_wr_bank_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        (buf_wr_en && disp_active) |-> (buf_wr_bank != cur_block[0])
    ) else $error("burst written into the displayed bank");

    a_burst_len: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == WAIT && !bus_wait) |=>
            (state == READ_DATA) [*`SCAN_BURST_LEN] ##1 (state == FINISH)
    ) else $error("READ_DATA did not last one full burst");

endmodule

`default_nettype wire

// File: src/pixel_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "scan_params.svh"

module pixel_buffer
    import bus_pkg::*, video_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  logic      wr_bank,
    input  buf_addr_t wr_addr,
    input  bus_data_t wr_data,
    input  raster_t   hcount,
    input  raster_t   vcount,
    output pixel_t    pixel,
    output logic      pixel_valid
);

    localparam raster_t H_VIS = raster_t'(`SCAN_H_VISIBLE);
    localparam raster_t V_VIS = raster_t'(`SCAN_V_VISIBLE);
    localparam int      DEPTH = `SCAN_BURST_LEN;

    bus_data_t mem [0:1][0:DEPTH-1];

    logic [9:0] rd_lcol;   // logical column
    logic       rd_bank;
    buf_addr_t  rd_addr;
    logic       rd_hi;
    logic       rd_de;
    bus_data_t  rd_word;

    assign rd_lcol = hcount[10:1];
    assign rd_bank = rd_lcol[$clog2(`SCAN_BLOCK_PIX)];  // block parity
    assign rd_addr = buf_addr_t'(rd_lcol >> 1);
    assign rd_hi   = !rd_lcol[0];                       // even pixel sits in the high byte
    assign rd_de   = (hcount < H_VIS) && (vcount < V_VIS);
    assign rd_word = mem[rd_bank][rd_addr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hi) begin
            pixel <= rd_word[15:8];
        end else begin
            pixel <= rd_word[7:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= rd_de;  // same latency as pixel
        end
    end

    a_no_read_collision: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en && rd_de) |-> (wr_bank != rd_bank)
    ) else $error("write into the bank being read");

endmodule

`default_nettype wire

// File: src/vga_scanout_top.sv
`timescale 1ns/1ps
`default_nettype none

module vga_scanout_top
    import bus_pkg::*, video_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  bus_addr_t base_addr,
    output logic      bus_req,
    input  logic      bus_ack,
    input  logic      bus_wait,
    output bus_addr_t bus_addr,
    output bus_ctrl_t bus_ctrl,
    input  bus_data_t bus_rdata,
    output logic      hsync,
    output logic      vsync,
    output pixel_t    pixel,
    output logic      pixel_valid,
    output logic      idle
);

    raster_t   hcount;
    raster_t   vcount;
    logic      hsync_raw;
    logic      vsync_raw;
    logic      buf_wr_en;
    logic      buf_wr_bank;
    buf_addr_t buf_wr_addr;

    vga_timing u_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync_raw),
        .vsync  (vsync_raw),
        .de     ()
    );

    fb_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .base_addr   (base_addr),
        .hcount      (hcount),
        .vcount      (vcount),
        .bus_req     (bus_req),
        .bus_ack     (bus_ack),
        .bus_wait    (bus_wait),
        .bus_addr    (bus_addr),
        .bus_ctrl    (bus_ctrl),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_bank (buf_wr_bank),
        .buf_wr_addr (buf_wr_addr),
        .idle        (idle)
    );

    pixel_buffer u_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (buf_wr_en),
        .wr_bank     (buf_wr_bank),
        .wr_addr     (buf_wr_addr),
        .wr_data     (bus_rdata),
        .hcount      (hcount),
        .vcount      (vcount),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

    // syncs delayed one clock to line up with the registered pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= hsync_raw;
            vsync <= vsync_raw;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_vga_scanout.sv
`timescale 1ns/1ps
`default_nettype none
`include "scan_params.svh"

module tb_vga_scanout
    import bus_pkg::*, video_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int CHECK_LINES  = 8;
    localparam int WATCHDOG_NS  = 12 * `SCAN_H_TOTAL * CLK_PERIOD;
    localparam int BLOCKS       = `SCAN_LOGICAL_W / `SCAN_BLOCK_PIX;

    logic      clk;
    logic      rst_n;
    bus_addr_t base_addr;
    logic      bus_req;
    logic      bus_ack;
    logic      bus_wait;
    bus_addr_t bus_addr;
    bus_ctrl_t bus_ctrl;
    bus_data_t bus_rdata;
    logic      hsync;
    logic      vsync;
    pixel_t    pixel;
    logic      pixel_valid;
    logic      idle;

    int         row;        // display line, counted from hsync
    int         col;        // pixel_valid cycles on the current line
    int         low_len;
    int         period;
    int         req_count;  // bursts requested so far
    logic       hsync_q;
    logic       req_q;
    logic       falls_seen;
    logic       reset_settled;
    bus_addr_t  addr_q;
    bus_addr_t  addr_off;
    bus_addr_t  exp_off;
    pixel_t     exp_pixel;
    logic [4:0] reset_view;

    vga_scanout_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .base_addr   (base_addr),
        .bus_req     (bus_req),
        .bus_ack     (bus_ack),
        .bus_wait    (bus_wait),
        .bus_addr    (bus_addr),
        .bus_ctrl    (bus_ctrl),
        .bus_rdata   (bus_rdata),
        .hsync       (hsync),
        .vsync       (vsync),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .idle        (idle)
    );

    // contents of the external memory
    function automatic bus_data_t mem_word(input bus_addr_t a);
        bus_addr_t p;
        p = a * 32'h9e37;
        return p[15:0];
    endfunction

    // each stored pixel covers 2x2 screen pixels, even pixel in the high byte
    function automatic pixel_t pixel_at(input bus_addr_t base, input int r, input int c);
        bus_data_t w;
        int        lcol;
        lcol = c / 2;
        w = mem_word(base + bus_addr_t'(((r / 2) * `SCAN_LOGICAL_W + lcol) / 2));
        if (lcol % 2 == 0) begin
            return w[15:8];
        end
        return w[7:0];
    endfunction

    task automatic stop_run;
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic show_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, sig, expected, actual);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        stop_run();
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n         = 1'b0;
        reset_settled = 1'b0;
        base_addr     = 32'h0002_4a10;
        repeat (2) @(negedge clk);
        reset_settled = 1'b1;  // reset values have been applied by now
        repeat (RESET_CYCLES - 2) @(negedge clk);
        rst_n = 1'b1;
        while (row < CHECK_LINES) begin
            @(negedge clk);
        end
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error at %0t: watchdog expired before %0d lines were checked",
                 $time, CHECK_LINES);
        stop_run();
    end

    // bus memory: random ack delay and wait length, then 16 data beats
    initial begin : memory_model
        int        ack_delay;
        int        wait_len;
        bus_addr_t burst_addr;
        void'($urandom(32'h360c));
        bus_ack   = 1'b0;
        bus_wait  = 1'b0;
        bus_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && bus_req) begin
                burst_addr = bus_addr;
                ack_delay  = $urandom_range(8);
                wait_len   = $urandom_range(16);
                repeat (ack_delay) @(negedge clk);
                bus_ack = 1'b1;
                @(negedge clk);       // ack taken on the edge in between
                bus_ack  = 1'b0;
                bus_wait = (wait_len != 0);
                @(negedge clk);       // PRESENT_ADDR cycle
                repeat (wait_len) @(negedge clk);
                bus_wait = 1'b0;
                @(negedge clk);
                for (int i = 0; i < `SCAN_BURST_LEN; i++) begin
                    bus_rdata = mem_word(burst_addr + bus_addr_t'(i));
                    @(negedge clk);
                end
                bus_rdata = '0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            row        <= 0;
            col        <= 0;
            low_len    <= 0;
            period     <= 0;
            req_count  <= 0;
            hsync_q    <= 1'b1;
            req_q      <= 1'b0;
            falls_seen <= 1'b0;
            addr_q     <= '0;
        end else begin
            hsync_q <= hsync;
            req_q   <= bus_req;
            addr_q  <= bus_addr;
            if (bus_req && !req_q) begin
                req_count <= req_count + 1;
            end
            if (pixel_valid) begin
                col <= col + 1;
            end
            if (!hsync) begin
                low_len <= low_len + 1;
            end else if (!hsync_q) begin
                low_len <= 0;
            end
            if (hsync_q && !hsync) begin  // hsync falls after the visible part
                falls_seen <= 1'b1;
                period     <= 1;
                if (col != 0) begin
                    row <= row + 1;
                    col <= 0;
                end
            end else begin
                period <= period + 1;
            end
        end
    end

    assign addr_off   = bus_addr - base_addr;
    assign reset_view = {bus_req, pixel_valid, hsync, vsync, idle};

    // ten bursts per line, two lines per stored row
    always_comb begin
        exp_off = bus_addr_t'((req_count / (2 * BLOCKS)) * (`SCAN_LOGICAL_W / 2)
                              + (req_count % BLOCKS) * `SCAN_BURST_LEN);
        exp_pixel = pixel_at(base_addr, row, col);
    end

    a_reset_state: assert property (@(posedge clk)
        (reset_settled && !rst_n) |-> (reset_view == 5'b00111)
    ) else show_mismatch("{bus_req,pixel_valid,hsync,vsync,idle}", 32'h7,
                         32'($sampled(reset_view)));

    a_vsync_high: assert property (@(posedge clk) disable iff (!rst_n)
        vsync
    ) else show_mismatch("vsync", 32'h1, 32'h0);

    a_hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        (hsync && !hsync_q) |-> (low_len == `SCAN_H_SYNC_LEN)
    ) else show_mismatch("hsync low cycles", `SCAN_H_SYNC_LEN, 32'($sampled(low_len)));

    a_hsync_period: assert property (@(posedge clk) disable iff (!rst_n)
        (falls_seen && hsync_q && !hsync) |-> (period == `SCAN_H_TOTAL)
    ) else show_mismatch("hsync period", `SCAN_H_TOTAL, 32'($sampled(period)));

    a_line_pixels: assert property (@(posedge clk) disable iff (!rst_n)
        (hsync_q && !hsync && col != 0) |-> (col == `SCAN_H_VISIBLE)
    ) else show_mismatch("pixel_valid cycles per line", `SCAN_H_VISIBLE, 32'($sampled(col)));

    a_pixel_value: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid |-> (pixel == exp_pixel)
    ) else show_mismatch("pixel", 32'($sampled(exp_pixel)), 32'($sampled(pixel)));

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req && req_q) |-> (bus_addr == addr_q)
    ) else show_mismatch("bus_addr", $sampled(addr_q), $sampled(bus_addr));

    a_ctrl_code: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req |-> (bus_ctrl == 8'h10)
    ) else show_mismatch("bus_ctrl", 32'h10, 32'($sampled(bus_ctrl)));

    a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req |-> (addr_off[3:0] == 4'h0)
    ) else report_failure("bus_addr is not on a 16-word block boundary");

    a_block_order: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req && !req_q) |-> (addr_off == exp_off)
    ) else show_mismatch("bus_addr - base_addr", $sampled(exp_off), $sampled(addr_off));

    // a pending request means the engine is busy
    a_busy_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req |-> !idle
    ) else show_mismatch("idle", 32'h0, 32'h1);

    // block 0 of the next line is loaded before hsync ends
    a_idle_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (hsync && !hsync_q) |-> idle
    ) else show_mismatch("idle", 32'h1, 32'h0);

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/bus_pkg.sv
src/video_pkg.sv
src/vga_timing.sv
src/fb_fetch.sv
src/pixel_buffer.sv
src/vga_scanout_top.sv
testbench/tb_vga_scanout.sv

// File: run_sim.sh
#!/bin/sh
# build and run the VGA scan-out testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vga_scanout -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_vga_scanout 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
